/* compile.f */
+incdir+.
icache_pkg.sv
icache_read_if.sv
icache_fill_if.sv
icache_storage.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* icache_cfg.svh */
// size constants for the two-way instruction cache, included by the package and the RTL
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ------------------------------------------------------------------------
// base sizes
// ------------------------------------------------------------------------
`define ICACHE_ADDR_W      32  // byte address
`define ICACHE_DATA_W      64  // cpu word
`define ICACHE_LINE_BYTES  32  // bytes per line
`define ICACHE_SETS        64  // sets per way

// ------------------------------------------------------------------------
// derived field widths
// ------------------------------------------------------------------------
`define ICACHE_WORDS     ((`ICACHE_LINE_BYTES * 8) / `ICACHE_DATA_W)  // words per line
`define ICACHE_OFFSET_W  $clog2(`ICACHE_LINE_BYTES)  // addr[4:0]
`define ICACHE_INDEX_W   $clog2(`ICACHE_SETS)  // addr[10:5]
`define ICACHE_TAG_W     (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)
// word select is the top of the offset field, addr[4:3]
`define ICACHE_WSEL_W    $clog2(`ICACHE_WORDS)

`endif

/* icache_ctrl.sv */
// cache controller: request buffer, tag compare, victim choice, refill counter and FSM
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst,
  // cpu side
  input  logic         i_valid,
  input  addr_t        i_addr,
  output logic         o_addr_ok,
  output logic         o_data_ok,
  output word_t        o_rdata,
  // memory side
  output logic         o_rd_req,
  output addr_t        o_rd_addr,
  input  logic         i_rd_rdy,
  input  logic         i_ret_valid,
  input  logic         i_ret_last,
  input  word_t        i_ret_data,
  // storage
  icache_read_if.ctrl  rd,
  icache_fill_if.ctrl  fill
);

  icache_state_e state_q;
  icache_state_e state_d;

  logic   accept;       // request taken this cycle
  logic   in_lookup;
  logic   in_refill;
  logic   hit;
  logic [1:0] way_hit;
  logic   miss_start;   // lookup found a miss
  logic   rd_fire;      // line read handshake
  logic   refill_done;  // last beat arrived

  tag_t   req_tag;
  index_t req_index;
  wsel_t  req_wsel;

  way_t   victim;
  way_t   victim_q;
  way_t   rr_ptr;
  wsel_t  beat_q;

  line_t  hit_line;

  // ------------------------------------------------------------------------
  // request buffer
  // ------------------------------------------------------------------------
  assign in_lookup = (state_q == LOOKUP);
  assign in_refill = (state_q == REFILL);
  assign accept    = i_valid && o_addr_ok;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_tag   <= i_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
      req_index <= i_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
      req_wsel  <= i_addr[`ICACHE_OFFSET_W-1 -: `ICACHE_WSEL_W];  // addr[4:3]
    end
  end

  // set read goes out with the request, tags come back in LOOKUP
  assign rd.rd_en    = accept;
  assign rd.rd_index = i_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  // ------------------------------------------------------------------------
  // tag compare and word select
  // ------------------------------------------------------------------------
  assign way_hit[0] = rd.way_valid[0] && (rd.way_tag[0] == req_tag);
  assign way_hit[1] = rd.way_valid[1] && (rd.way_tag[1] == req_tag);
  assign hit        = |way_hit;

  assign miss_start = in_lookup && !hit;
  assign hit_line   = way_hit[1] ? rd.way_line[1] : rd.way_line[0];

  // ------------------------------------------------------------------------
  // victim choice, empty way first, then round robin
  // ------------------------------------------------------------------------
  always_comb begin
    if (!rd.way_valid[0]) begin
      victim = 1'b0;
    end else if (!rd.way_valid[1]) begin
      victim = 1'b1;
    end else begin
      victim = rr_ptr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (miss_start) begin
      victim_q <= victim;  // held for the whole refill
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_ptr <= 1'b0;
    end else if (refill_done) begin
      rr_ptr <= ~rr_ptr;
    end
  end

  // ------------------------------------------------------------------------
  // beat counter
  // ------------------------------------------------------------------------
  assign rd_fire     = o_rd_req && i_rd_rdy;
  assign refill_done = in_refill && i_ret_valid && i_ret_last;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      beat_q <= '0;
    end else if (rd_fire) begin
      beat_q <= '0;  // beats start at word 0
    end else if (in_refill && i_ret_valid) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign fill.fill_en    = in_refill && i_ret_valid;
  assign fill.fill_way   = victim_q;
  assign fill.fill_index = req_index;
  assign fill.fill_wsel  = beat_q;
  assign fill.fill_data  = i_ret_data;
  assign fill.fill_tag   = req_tag;
  assign fill.fill_last  = i_ret_last;

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_d = accept ? LOOKUP : IDLE;  // streaming hits stay here
        end else begin
          state_d = i_rd_rdy ? REFILL : MISS_REQ;
        end
      end
      MISS_REQ: begin
        if (i_rd_rdy) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (refill_done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------
  assign o_addr_ok = (state_q == IDLE) || (in_lookup && hit);
  assign o_data_ok = (in_lookup && hit) || (in_refill && i_ret_valid && (beat_q == req_wsel));
  assign o_rdata   = in_lookup ? hit_line[req_wsel*`ICACHE_DATA_W +: `ICACHE_DATA_W]
                               : i_ret_data;  // missing word straight from memory

  // request rises already in LOOKUP on a miss
  assign o_rd_req  = miss_start || (state_q == MISS_REQ);
  assign o_rd_addr = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};  // line aligned

endmodule

`default_nettype wire

/* icache_fill_if.sv */
// refill write port from the cache controller into the tag/data storage
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

interface icache_fill_if import icache_pkg::*; ();

  logic   fill_en;     // write one beat
  way_t   fill_way;    // victim way
  index_t fill_index;  // set being refilled
  wsel_t  fill_wsel;   // word within the line
  word_t  fill_data;   // returned beat
  tag_t   fill_tag;    // tag of the new line
  logic   fill_last;   // final beat, sets tag and valid

  modport ctrl (output fill_en, fill_way, fill_index, fill_wsel,
                       fill_data, fill_tag, fill_last);

  modport store (input fill_en, fill_way, fill_index, fill_wsel,
                       fill_data, fill_tag, fill_last);

endinterface

`default_nettype wire

/* icache_pkg.sv */
// shared types of the instruction cache, imported by every RTL file
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  // ------------------------------------------------------------------------
  // address fields and data
  // ------------------------------------------------------------------------
  typedef logic [`ICACHE_ADDR_W-1:0]        addr_t;   // byte address
  typedef logic [`ICACHE_DATA_W-1:0]        word_t;   // one cpu word
  typedef logic [`ICACHE_LINE_BYTES*8-1:0]  line_t;   // four words, word 0 at lsb
  typedef logic [`ICACHE_TAG_W-1:0]         tag_t;    // addr[31:11]
  typedef logic [`ICACHE_INDEX_W-1:0]       index_t;  // addr[10:5]
  typedef logic [`ICACHE_WSEL_W-1:0]        wsel_t;   // addr[4:3]
  typedef logic                             way_t;    // two ways

  // controller FSM
  typedef enum logic [1:0] {
    IDLE,      // ready for a new request
    LOOKUP,    // tags of the buffered request are on the read port
    MISS_REQ,  // waiting for the line read to be taken
    REFILL     // beats coming back from memory
  } icache_state_e;

endpackage

`default_nettype wire

/* icache_read_if.sv */
// set read port between the cache controller and the tag/data storage
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

interface icache_read_if import icache_pkg::*; ();

  logic       rd_en;         // read the set this cycle
  index_t     rd_index;      // set to read
  logic [1:0] way_valid;     // one bit per way
  tag_t       way_tag [2];   // stored tags
  line_t      way_line [2];  // stored lines

  // values show up one clock after rd_en and hold until the next one
  modport ctrl (output rd_en, rd_index,
                input  way_valid, way_tag, way_line);

  modport store (input  rd_en, rd_index,
                 output way_valid, way_tag, way_line);

endinterface

`default_nettype wire

/* icache_storage.sv */
// valid, tag and data arrays of both ways, registered set read and per-beat refill write
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_storage import icache_pkg::*; (
  input  logic          i_clk,
  input  logic          i_rst,
  icache_read_if.store  rd,
  icache_fill_if.store  fill
);

  // ------------------------------------------------------------------------
  // arrays
  // ------------------------------------------------------------------------
  logic [`ICACHE_SETS-1:0] valid_q [2];  // one bit per set and way
  tag_t  tag_mem  [2][`ICACHE_SETS];
  word_t data_mem [2][`ICACHE_SETS][`ICACHE_WORDS];  // word granular for refill

  logic fill_done;  // last beat of a line

  assign fill_done = fill.fill_en && fill.fill_last;

  // ------------------------------------------------------------------------
  // valid bits, the only state cleared by reset
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end else if (fill_done) begin
      valid_q[fill.fill_way][fill.fill_index] <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // refill writes
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (fill.fill_en) begin
      data_mem[fill.fill_way][fill.fill_index][fill.fill_wsel] <= fill.fill_data;
    end
    if (fill_done) begin
      tag_mem[fill.fill_way][fill.fill_index] <= fill.fill_tag;  // line now complete
    end
  end

  // ------------------------------------------------------------------------
  // registered set read, like the one-cycle SRAM macro
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (rd.rd_en) begin
      for (int w = 0; w < 2; w++) begin
        rd.way_valid[w] <= valid_q[w][rd.rd_index];
        rd.way_tag[w]   <= tag_mem[w][rd.rd_index];
        for (int i = 0; i < `ICACHE_WORDS; i++) begin
          // word 0 sits in the low bits of the line
          rd.way_line[w][i*`ICACHE_DATA_W +: `ICACHE_DATA_W] <= data_mem[w][rd.rd_index][i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* icache_top.sv */
// instruction cache top level with plain cpu and memory ports
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  // cpu side
  input  logic  i_valid,
  input  addr_t i_addr,
  output logic  o_addr_ok,
  output logic  o_data_ok,
  output word_t o_rdata,
  // memory side
  output logic  o_rd_req,
  output addr_t o_rd_addr,
  input  logic  i_rd_rdy,
  input  logic  i_ret_valid,
  input  logic  i_ret_last,
  input  word_t i_ret_data
);

  icache_read_if rd_if ();    // set read
  icache_fill_if fill_if ();  // refill writes

  icache_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .rd          (rd_if.ctrl),
    .fill        (fill_if.ctrl)
  );

  icache_storage u_storage (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .rd    (rd_if.store),
    .fill  (fill_if.store)
  );

endmodule

`default_nettype wire

/* icache_trace.txt */
// columns: request byte address, expected read data, miss flag
// miss is 1 when the request is expected to raise a line read to memory
00001008 00001008ffffeff7 1
00001000 00001000ffffefff 0
00001018 00001018ffffefe7 0
00001010 00001010ffffefef 0
00001818 00001818ffffe7e7 1
00001800 00001800ffffe7ff 0
00001008 00001008ffffeff7 0
00002010 00002010ffffdfef 1
00001808 00001808ffffe7f7 0
00001000 00001000ffffefff 1
00001810 00001810ffffe7ef 1
00001018 00001018ffffefe7 0
00002000 00002000ffffdfff 1
00001800 00001800ffffe7ff 0
00000fe8 00000fe8fffff017 1
00000ff8 00000ff8fffff007 0
12345678 12345678edcba987 1
12345660 12345660edcba99f 0
00001008 00001008ffffeff7 1
00001800 00001800ffffe7ff 1

/* tb_icache.sv */
// testbench for the instruction cache that plays icache_trace.txt against a memory model
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module tb_icache;

  localparam int CLK_PERIOD = 8;
  localparam int ADDR_W     = `ICACHE_ADDR_W;
  localparam int DATA_W     = `ICACHE_DATA_W;
  localparam int OFFSET_W   = `ICACHE_OFFSET_W;
  localparam int WORDS      = `ICACHE_WORDS;
  localparam int TRACE_MAX  = 32;

  logic              i_clk;
  logic              i_rst;
  logic              i_valid;
  logic [ADDR_W-1:0] i_addr;
  logic              o_addr_ok;
  logic              o_data_ok;
  logic [DATA_W-1:0] o_rdata;
  logic              o_rd_req;
  logic [ADDR_W-1:0] o_rd_addr;
  logic              i_rd_rdy;
  logic              i_ret_valid;
  logic              i_ret_last;
  logic [DATA_W-1:0] i_ret_data;

  logic [63:0] trace_mem [3*TRACE_MAX];  // addr, data, miss per entry
  int          trace_len = 0;
  logic [15:0] lfsr_q = 16'd79;

  icache_top dut_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, expected);
      abort_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = (val << 1) | lfsr_q[0];  // one step per bit
    end
  endtask

  // byte address in the upper half and its inverse in the lower half
  function automatic logic [DATA_W-1:0] memory_word(input logic [ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] a);
    return (a >> OFFSET_W) << OFFSET_W;
  endfunction

  task automatic load_trace();
    for (int i = 0; i < 3*TRACE_MAX; i++) begin
      trace_mem[i] = '1;  // marks unused entries
    end
    $readmemh("icache_trace.txt", trace_mem);
    while (trace_len < TRACE_MAX && trace_mem[3*trace_len] != '1) begin
      trace_len++;
    end
  endtask

  // --------------------------------------------------------------------------
  // CPU side issues requests in order and checks lookups and answers
  // --------------------------------------------------------------------------
  task automatic run_trace();
    int   issued;
    int   answered;
    int   look_idx;
    int   k;
    int   pending[$];
    logic refilling;
    issued    = 0;
    answered  = 0;
    look_idx  = -1;
    refilling = 1'b0;
    while (answered < trace_len) begin
      @(posedge i_clk);
      #1;
      if (issued < trace_len) begin
        i_valid = 1'b1;
        i_addr  = trace_mem[3*issued][ADDR_W-1:0];
      end else begin
        i_valid = 1'b0;
        i_addr  = '0;
      end
      @(negedge i_clk);
      if (refilling) begin  // miss in progress
        check_value("o_addr_ok", o_addr_ok, 1'b0);
        if (i_ret_valid && i_ret_last) begin
          refilling = 1'b0;
        end
      end
      if (look_idx >= 0) begin  // cycle after acceptance
        check_value("o_rd_req", o_rd_req, trace_mem[3*look_idx+2][0]);
        check_value("o_data_ok", o_data_ok, !trace_mem[3*look_idx+2][0]);
        if (i_valid) begin
          check_value("o_addr_ok", o_addr_ok, !trace_mem[3*look_idx+2][0]);  // hits stream
        end
        if (o_rd_req) begin
          check_value("o_rd_addr", o_rd_addr, line_base(trace_mem[3*look_idx][ADDR_W-1:0]));
        end
        refilling = trace_mem[3*look_idx+2][0];
        look_idx  = -1;
      end
      if (o_data_ok) begin
        if (pending.size() == 0) begin
          $display("ERROR: o_data_ok pulsed with no request outstanding");
          abort_run();
        end
        k = pending.pop_front();
        check_value("o_rdata", o_rdata, trace_mem[3*k+1]);
        answered++;
      end
      if (i_valid && o_addr_ok) begin
        pending.push_back(issued);
        look_idx = issued;
        issued++;
      end
    end
    // no stray answers or line reads once the trace is done
    repeat (4) begin
      @(negedge i_clk);
      check_value("o_data_ok", o_data_ok, 1'b0);
      check_value("o_rd_req", o_rd_req, 1'b0);
    end
  endtask

  // --------------------------------------------------------------------------
  // memory responder
  // --------------------------------------------------------------------------
  initial begin : memory_responder
    logic [ADDR_W-1:0] req_addr;
    int delay;
    int gap;
    forever begin
      @(negedge i_clk);
      if (o_rd_req) begin
        req_addr = o_rd_addr;
        take_bits(2, delay);  // 0 to 3 cycles of back-pressure
        repeat (delay) begin
          @(negedge i_clk);
          check_value("o_rd_req", o_rd_req, 1'b1);
          check_value("o_rd_addr", o_rd_addr, req_addr);
        end
        @(posedge i_clk);
        #1;
        i_rd_rdy = 1'b1;
        @(negedge i_clk);
        check_value("o_rd_req", o_rd_req, 1'b1);
        check_value("o_rd_addr", o_rd_addr, req_addr);
        @(posedge i_clk);
        #1;
        i_rd_rdy = 1'b0;
        for (int b = 0; b < WORDS; b++) begin
          take_bits(1, gap);
          if (gap != 0) begin
            i_ret_valid = 1'b0;  // idle cycle between beats
            @(posedge i_clk);
            #1;
          end
          i_ret_valid = 1'b1;
          i_ret_last  = (b == WORDS-1);
          i_ret_data  = memory_word(req_addr + b*(DATA_W/8));
          @(posedge i_clk);
          #1;
        end
        i_ret_valid = 1'b0;
        i_ret_last  = 1'b0;
        i_ret_data  = '0;
      end
    end
  end

  // watchdog allows 40 cycles per trace entry
  initial begin
    wait (trace_len > 0 && i_rst === 1'b0);
    repeat (trace_len * 40) @(posedge i_clk);
    $display("ERROR: watchdog expired before all trace requests were answered");
    abort_run();
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_addr      = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    load_trace();
    if (trace_len == 0) begin
      $display("ERROR: no requests could be read from icache_trace.txt");
      abort_run();
    end
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    check_value("o_addr_ok", o_addr_ok, 1'b1);  // IDLE after reset
    check_value("o_rd_req", o_rd_req, 1'b0);
    check_value("o_data_ok", o_data_ok, 1'b0);
    run_trace();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
